// ==== ifetch.f ====
+incdir+src
src/ifetch_pkg.sv
src/l1_itlb.sv
src/icache_core.sv
src/line_fill_reader.sv
src/ifetch_top.sv
verification/ifetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the ifetch testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f ifetch.f --top-module ifetch_tb -o ifetch_sim > "$LOG" 2>&1 &&
    ./obj_dir/ifetch_sim >> "$LOG" 2>&1 ||
    echo "Simulation FAILED" >> "$LOG"

cat "$LOG"
grep -q "Simulation FAILED" "$LOG" && exit 1
exit 0

// ==== src/icache_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ifetch_defs.svh"

module icache_core
    import ifetch_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire           inst_en,
    input  wire vaddr_t   inst_va,
    input  wire vaddr_t   inst_va_next,
    input  wire           stall_f,
    input  wire           fence_i,
    input  wire vaddr_t   fence_addr,
    input  wire           fence_tlb,
    input  wire xlate_t   xlate,
    output logic          refill_start,
    output logic          tlb_flush,
    input  wire           refill_fault,
    input  wire           refill_invalid,
    output logic          fill_start,
    output logic          fill_single,
    output paddr_t        fill_addr,
    input  wire fill_wr_t fill_wr,
    input  wire word_t    rdata,
    input  wire           fill_done,
    output fetch_out_t    fetch,
    output logic          istall
);

    localparam int LEN_LINE  = `IFETCH_LEN_LINE;
    localparam int LEN_INDEX = `IFETCH_LEN_INDEX;
    localparam int NR_WAYS   = `IFETCH_NR_WAYS;
    localparam int LEN_TAG   = `IFETCH_LEN_TAG;
    localparam int NR_SETS   = 1 << LEN_INDEX;
    localparam int LEN_WADDR = LEN_INDEX + LEN_LINE - 3;
    localparam int SET_HI    = LEN_LINE + LEN_INDEX - 1;

    typedef logic [LEN_TAG-1:0]   tag_t;
    typedef logic [LEN_INDEX-1:0] set_t;
    typedef logic [LEN_WADDR-1:0] waddr_t;

    tag_t               tag_mem  [NR_WAYS][NR_SETS];
    logic [63:0]        data_mem [NR_WAYS][1 << LEN_WADDR];
    tag_t               rd_tag   [NR_WAYS];
    logic [63:0]        rd_data  [NR_WAYS];
    logic [NR_WAYS-1:0] valid_q  [NR_SETS];
    logic [NR_SETS-1:0] lru_q;

    icache_state_t      state;
    fetch_out_t         saved_q;
    logic               fence_i_ready;
    logic               fence_tlb_ready;
    logic               victim_q;
    set_t               fill_set_q;

    vaddr_t             rd_va;
    set_t               rd_set;
    set_t               cur_set;
    tag_t               cur_tag;
    logic [NR_WAYS-1:0] way_hit;
    logic               way_sel;
    logic [63:0]        hit_data;
    logic               hit_avail;
    logic               fence_i_go;
    logic               fence_tlb_go;
    logic               fetch_go;
    logic               victim;
    logic               tag_we;
    waddr_t             fill_waddr;
    logic [63:0]        fill_data;

    // arrays are read one cycle ahead while idle
    assign rd_va   = (state == IDLE || state == SAVE_RESULT) ? inst_va_next : inst_va;
    assign rd_set  = rd_va[SET_HI:LEN_LINE];
    assign cur_set = inst_va[SET_HI:LEN_LINE];
    assign cur_tag = xlate.paddr[31 -: LEN_TAG];

    always_comb begin
        for (int w = 0; w < NR_WAYS; w++) begin
            way_hit[w] = (rd_tag[w] == cur_tag) && valid_q[cur_set][w];
        end
    end

    assign way_sel  = way_hit[1];
    assign hit_data = rd_data[way_sel];
    assign victim   = lru_q[cur_set];

    // a fence held high is served once, until the next accepted fetch
    assign fence_i_go   = fence_i & ~fence_i_ready;
    assign fence_tlb_go = fence_tlb & ~fence_tlb_ready;
    assign fetch_go     = (state == IDLE) & ~fence_i_go & ~fence_tlb_go & inst_en;
    assign hit_avail    = (|way_hit) & xlate.ok & ~xlate.uncached & ~fence_i_go & ~fence_tlb_go;

    assign tlb_flush    = (state == IDLE) & (fence_i_go | fence_tlb_go);
    assign refill_start = fetch_go & ~xlate.ok;
    assign fill_start   = fetch_go & xlate.ok & (xlate.uncached | ~(|way_hit));
    assign fill_single  = xlate.uncached;
    assign fill_addr    = xlate.paddr;
    assign tag_we       = fill_start & ~xlate.uncached;

    assign fill_waddr = {fill_set_q, fill_wr.idx[LEN_LINE-3:1]};
    assign fill_data  = {rdata, rdata};

    always_ff @(posedge clk) begin
        for (int w = 0; w < NR_WAYS; w++) begin
            if (tag_we && victim == 1'(w)) begin
                tag_mem[w][cur_set] <= cur_tag;
            end
            for (int b = 0; b < 8; b++) begin
                if (victim_q == 1'(w) && fill_wr.strb[b]) begin
                    data_mem[w][fill_waddr][8*b +: 8] <= fill_data[8*b +: 8];
                end
            end
            rd_tag[w]  <= tag_mem[w][rd_set];
            rd_data[w] <= data_mem[w][{rd_set, rd_va[LEN_LINE-1:3]}];
        end
    end

    // target of the line being filled
    always_ff @(posedge clk) begin
        if (tag_we) begin
            victim_q   <= victim;
            fill_set_q <= cur_set;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= IDLE;
            fence_i_ready   <= 1'b0;
            fence_tlb_ready <= 1'b0;
            saved_q         <= '0;
            valid_q         <= '{default: '0};
            lru_q           <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (fence_i_go) begin
                        valid_q[fence_addr[SET_HI:LEN_LINE]] <= '0;
                        state <= FENCE;
                    end else if (fence_tlb_go) begin
                        state <= FENCE;
                    end else if (refill_start) begin
                        state <= TLB_FILL;
                    end else if (fill_start) begin
                        if (xlate.uncached) begin
                            state <= UNCACHED;
                        end else begin
                            valid_q[cur_set][victim] <= 1'b1;
                            state <= CACHE_REPLACE;
                        end
                    end else if (fetch_go && !stall_f) begin
                        fence_i_ready   <= 1'b0;
                        fence_tlb_ready <= 1'b0;
                        lru_q[cur_set]  <= ~way_sel;
                    end
                end
                FENCE: begin
                    fence_i_ready   <= 1'b1;
                    fence_tlb_ready <= 1'b1;
                    state <= IDLE;
                end
                TLB_FILL: begin
                    if (refill_fault || refill_invalid) begin
                        saved_q.rdata0      <= '0;
                        saved_q.ok0         <= 1'b1;
                        saved_q.tlb_refill  <= refill_fault;
                        saved_q.tlb_invalid <= refill_invalid;
                        state <= SAVE_RESULT;
                    end else begin
                        state <= IDLE;
                    end
                end
                UNCACHED: begin
                    if (fill_wr.last) begin
                        saved_q.rdata0 <= rdata;
                        saved_q.ok0    <= 1'b1;
                        state <= SAVE_RESULT;
                    end
                end
                CACHE_REPLACE: begin
                    if (fill_done) begin
                        state <= IDLE;
                    end
                end
                SAVE_RESULT: begin
                    if (!stall_f) begin
                        fence_i_ready   <= 1'b0;
                        fence_tlb_ready <= 1'b0;
                        saved_q         <= '0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_comb begin
        if (state == IDLE) begin
            fetch.rdata0      = inst_va[2] ? hit_data[63:32] : hit_data[31:0];
            fetch.rdata1      = hit_data[63:32];
            fetch.ok0         = hit_avail;
            fetch.ok1         = hit_avail & ~inst_va[2];
            fetch.tlb_refill  = 1'b0;
            fetch.tlb_invalid = 1'b0;
        end else begin
            fetch = saved_q;
        end
        fetch.ok0 = fetch.ok0 & inst_en;
        fetch.ok1 = fetch.ok1 & inst_en;
    end

    assign istall = (state == IDLE) ? (inst_en & ~hit_avail) : (state != SAVE_RESULT);

endmodule

`default_nettype wire

// ==== src/ifetch_defs.svh ====
`ifndef IFETCH_DEFS_SVH
`define IFETCH_DEFS_SVH

// log2 of line size in bytes
`define IFETCH_LEN_LINE 6

// log2 of number of sets
`define IFETCH_LEN_INDEX 6

// replacement logic assumes exactly two ways
`define IFETCH_NR_WAYS 2

`define IFETCH_LEN_TAG (32 - `IFETCH_LEN_LINE - `IFETCH_LEN_INDEX)

// 32-bit words per line
`define IFETCH_NR_WORDS (1 << (`IFETCH_LEN_LINE - 2))

`endif

// ==== src/ifetch_pkg.sv ====
`default_nettype none

`include "ifetch_defs.svh"

package ifetch_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [31:0] word_t;
    typedef logic [18:0] vpn2_t;
    typedef logic [19:0] pfn_t;

    // even page half first
    typedef struct packed {
        pfn_t       pfn0;
        logic [2:0] c0;
        logic       v0;
        pfn_t       pfn1;
        logic [2:0] c1;
        logic       v1;
    } tlb_entry_t;

    typedef struct packed {
        paddr_t paddr;
        logic   uncached;
        logic   ok;
    } xlate_t;

    typedef struct packed {
        word_t rdata0;
        word_t rdata1;
        logic  ok0;
        logic  ok1;
        logic  tlb_refill;
        logic  tlb_invalid;
    } fetch_out_t;

    typedef struct packed {
        paddr_t     araddr;
        logic [7:0] arlen;
        logic       arvalid;
    } ar_req_t;

    // one write beat into the data array
    typedef struct packed {
        logic [`IFETCH_LEN_LINE-3:0] idx;
        logic [7:0]                  strb;
        logic                        last;
    } fill_wr_t;

    typedef enum logic [2:0] {
        IDLE,
        FENCE,
        TLB_FILL,
        UNCACHED,
        CACHE_REPLACE,
        SAVE_RESULT
    } icache_state_t;

endpackage

`default_nettype wire

// ==== src/ifetch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ifetch_top
    import ifetch_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             inst_en,
    input  wire vaddr_t     inst_va,
    input  wire vaddr_t     inst_va_next,
    input  wire             stall_f,
    input  wire             fence_i,
    input  wire vaddr_t     fence_addr,
    input  wire             fence_tlb,
    output fetch_out_t      fetch,
    output logic            istall,
    output vpn2_t           itlb_vpn2,
    input  wire             itlb_found,
    input  wire tlb_entry_t itlb_entry,
    output paddr_t          araddr,
    output logic [7:0]      arlen,
    output logic [2:0]      arsize,
    output logic            arvalid,
    input  wire             arready,
    input  wire word_t      rdata,
    input  wire             rvalid,
    input  wire             rlast,
    output logic            rready
);

    xlate_t   xlate;
    logic     refill_start;
    logic     tlb_flush;
    logic     refill_fault;
    logic     refill_invalid;
    logic     fill_start;
    logic     fill_single;
    paddr_t   fill_addr;
    fill_wr_t fill_wr;
    logic     fill_done;

    l1_itlb u_itlb (
        .clk            (clk),
        .rst            (rst),
        .inst_va        (inst_va),
        .refill_start   (refill_start),
        .flush          (tlb_flush),
        .itlb_vpn2      (itlb_vpn2),
        .itlb_found     (itlb_found),
        .itlb_entry     (itlb_entry),
        .xlate          (xlate),
        .refill_fault   (refill_fault),
        .refill_invalid (refill_invalid)
    );

    icache_core u_core (
        .clk            (clk),
        .rst            (rst),
        .inst_en        (inst_en),
        .inst_va        (inst_va),
        .inst_va_next   (inst_va_next),
        .stall_f        (stall_f),
        .fence_i        (fence_i),
        .fence_addr     (fence_addr),
        .fence_tlb      (fence_tlb),
        .xlate          (xlate),
        .refill_start   (refill_start),
        .tlb_flush      (tlb_flush),
        .refill_fault   (refill_fault),
        .refill_invalid (refill_invalid),
        .fill_start     (fill_start),
        .fill_single    (fill_single),
        .fill_addr      (fill_addr),
        .fill_wr        (fill_wr),
        .rdata          (rdata),
        .fill_done      (fill_done),
        .fetch          (fetch),
        .istall         (istall)
    );

    line_fill_reader u_fill (
        .clk     (clk),
        .rst     (rst),
        .start   (fill_start),
        .single  (fill_single),
        .addr    (fill_addr),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arvalid (arvalid),
        .arready (arready),
        .rvalid  (rvalid),
        .rlast   (rlast),
        .rready  (rready),
        .fill_wr (fill_wr),
        .done    (fill_done)
    );

endmodule

`default_nettype wire

// ==== src/l1_itlb.sv ====
`timescale 1ns/100ps
`default_nettype none

module l1_itlb
    import ifetch_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire vaddr_t     inst_va,
    input  wire             refill_start,
    input  wire             flush,
    output vpn2_t           itlb_vpn2,
    input  wire             itlb_found,
    input  wire tlb_entry_t itlb_entry,
    output xlate_t          xlate,
    output logic            refill_fault,
    output logic            refill_invalid
);

    logic       tlb_valid;
    logic       tlb_odd;
    pfn_t       tlb_pfn;
    logic       tlb_uncached;
    logic       refill_pending;
    logic       direct;
    logic       tlb_hit;
    pfn_t       sel_pfn;
    logic [2:0] sel_c;
    logic       sel_v;

    // kseg0 and kseg1 bypass the TLB
    assign direct  = (inst_va[31:30] == 2'b10);
    assign tlb_hit = tlb_valid && (inst_va[31:13] == itlb_vpn2) && (inst_va[12] == tlb_odd);

    always_comb begin
        xlate.ok = direct | tlb_hit;
        if (direct) begin
            xlate.paddr    = {3'b000, inst_va[28:0]};
            xlate.uncached = inst_va[29];
        end else begin
            xlate.paddr    = {tlb_pfn, inst_va[11:0]};
            xlate.uncached = tlb_uncached;
        end
    end

    // pick the page half of the pair
    assign sel_pfn = tlb_odd ? itlb_entry.pfn1 : itlb_entry.pfn0;
    assign sel_c   = tlb_odd ? itlb_entry.c1 : itlb_entry.c0;
    assign sel_v   = tlb_odd ? itlb_entry.v1 : itlb_entry.v0;

    assign refill_fault   = refill_pending & ~itlb_found;
    assign refill_invalid = refill_pending & itlb_found & ~sel_v;

    always_ff @(posedge clk) begin
        if (rst) begin
            tlb_valid      <= 1'b0;
            tlb_odd        <= 1'b0;
            refill_pending <= 1'b0;
            itlb_vpn2      <= '0;
        end else begin
            refill_pending <= refill_start;
            if (refill_start) begin
                itlb_vpn2 <= inst_va[31:13];
                tlb_odd   <= inst_va[12];
                tlb_valid <= 1'b0;
            end else if (flush) begin
                tlb_valid <= 1'b0;
            end else if (refill_pending && itlb_found && sel_v) begin
                tlb_valid <= 1'b1;
            end
        end
    end

    // C == 2 is the uncached attribute
    always_ff @(posedge clk) begin
        if (refill_pending) begin
            tlb_pfn      <= sel_pfn;
            tlb_uncached <= (sel_c == 3'd2);
        end
    end

endmodule

`default_nettype wire

// ==== src/line_fill_reader.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ifetch_defs.svh"

module line_fill_reader
    import ifetch_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         start,
    input  wire         single,
    input  wire paddr_t addr,
    output paddr_t      araddr,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic        arvalid,
    input  wire         arready,
    input  wire         rvalid,
    input  wire         rlast,
    output logic        rready,
    output fill_wr_t    fill_wr,
    output logic        done
);

    localparam int LEN_LINE = `IFETCH_LEN_LINE;

    ar_req_t               ar_q;
    logic                  single_q;
    logic [LEN_LINE-3:0]   beat_idx;
    logic                  beat;

    assign araddr  = ar_q.araddr;
    assign arlen   = ar_q.arlen;
    assign arvalid = ar_q.arvalid;
    // always 4-byte beats
    assign arsize  = 3'd2;

    assign beat = rvalid & rready;

    // even words go to the low half of the 64-bit array word
    always_comb begin
        fill_wr.idx  = beat_idx;
        fill_wr.strb = 8'h00;
        if (beat && !single_q) begin
            fill_wr.strb = beat_idx[0] ? 8'hf0 : 8'h0f;
        end
        fill_wr.last = beat & rlast;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_q     <= '0;
            rready   <= 1'b0;
            single_q <= 1'b0;
            beat_idx <= '0;
            done     <= 1'b0;
        end else begin
            done <= fill_wr.last;
            if (start) begin
                ar_q.araddr  <= single ? addr : {addr[31:LEN_LINE], {LEN_LINE{1'b0}}};
                ar_q.arlen   <= single ? 8'd0 : 8'(`IFETCH_NR_WORDS - 1);
                ar_q.arvalid <= 1'b1;
                single_q     <= single;
                beat_idx     <= '0;
            end else if (ar_q.arvalid && arready) begin
                ar_q.arvalid <= 1'b0;
                rready       <= 1'b1;
            end
            if (beat) begin
                beat_idx <= beat_idx + 1'b1;
            end
            if (fill_wr.last) begin
                rready <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/ifetch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ifetch_defs.svh"

module ifetch_tb
    import ifetch_pkg::*;
;

    localparam int NUM_OPS    = 300;
    localparam int WORST_FILL = 8 + `IFETCH_NR_WORDS * 5 + 16;
    localparam int TIMEOUT    = NUM_OPS * WORST_FILL + 1000;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       inst_en = 1'b0;
    vaddr_t     inst_va = '0;
    vaddr_t     inst_va_next = '0;
    logic       stall_f = 1'b0;
    logic       fence_i = 1'b0;
    vaddr_t     fence_addr = '0;
    logic       fence_tlb = 1'b0;
    fetch_out_t fetch;
    logic       istall;
    vpn2_t      itlb_vpn2;
    logic       itlb_found = 1'b0;
    tlb_entry_t itlb_entry = '0;
    paddr_t     araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic       arvalid;
    logic       arready = 1'b0;
    word_t      rdata = '0;
    logic       rvalid = 1'b0;
    logic       rlast = 1'b0;
    logic       rready;

    // reference state
    logic [19:0] m_tag [2][64];
    logic [1:0]  m_val [64];
    logic        m_lru [64];
    logic        m_tlb_valid;
    vpn2_t       m_vpn;
    logic        m_odd;
    pfn_t        m_pfn;
    logic        m_unc;
    logic        pt_found [3];
    tlb_entry_t  pt_entry [3];

    paddr_t      req_addr_q [$];
    logic [7:0]  req_len_q [$];
    int          lookup_cnt = 0;
    int          cycles = 0;
    int          ar_wait = 0;
    int          beat_wait = 0;
    int          beats_left = 0;
    paddr_t      beat_addr = '0;

    ifetch_top DUT (.*);

    always #50 clk = ~clk;

    function automatic word_t mem_word(input paddr_t a);
        word_t x;
        x = (a ^ 32'h5bd1_e995) * 32'h9e37_79b1;
        x = x ^ (x >> 15) ^ (a << 7);
        return x;
    endfunction

    function automatic pfn_t pick_ptag(input int k);
        case (k % 4)
            0: return 20'h00011;
            1: return 20'h00022;
            2: return 20'h00033;
            default: return 20'h00044;
        endcase
    endfunction

    function automatic logic [5:0] pick_set();
        case ($urandom % 3)
            0: return 6'd5;
            1: return 6'd6;
            default: return 6'd33;
        endcase
    endfunction

    task automatic stop_run();
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t got);
        if (exp !== got) begin
            $display("ERR %s expected %08h got %08h", name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_fetch(input string name, input fetch_out_t exp, input fetch_out_t got);
        if (exp !== got) begin
            $display("ERR %s expected %h got %h", name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input paddr_t exp, input paddr_t got);
        if (exp !== got) begin
            $display("ERR %s expected %08h got %08h", name, exp, got);
            stop_run();
        end
    endtask

    // L2 TLB answers whatever vpn2 the DUT holds
    always @(negedge clk) begin
        if (itlb_vpn2 >= 19'h200 && itlb_vpn2 <= 19'h202) begin
            itlb_found = pt_found[itlb_vpn2 - 19'h200];
            itlb_entry = pt_entry[itlb_vpn2 - 19'h200];
        end else begin
            itlb_found = 1'b0;
            itlb_entry = '0;
        end
    end

    // count L2 TLB lookups issued by the DUT
    always @(posedge clk) begin
        if (!rst && DUT.refill_start) begin
            lookup_cnt++;
        end
    end

    // AXI read slave with random gaps
    always @(negedge clk) begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        if (!rst) begin
            if (arvalid) begin
                if (ar_wait == 0) begin
                    arready = 1'b1;
                    // 4-byte beats
                    check_word("arsize", 32'd2, {29'd0, arsize});
                    req_addr_q.push_back(araddr);
                    req_len_q.push_back(arlen);
                    beats_left = int'(arlen) + 1;
                    beat_addr  = araddr;
                    ar_wait    = $urandom % 4;
                    beat_wait  = $urandom % 4;
                end else begin
                    ar_wait--;
                end
            end else if (beats_left > 0 && rready) begin
                if (beat_wait == 0) begin
                    rvalid = 1'b1;
                    rdata  = mem_word(beat_addr);
                    rlast  = (beats_left == 1);
                    beat_addr  = beat_addr + 4;
                    beats_left--;
                    beat_wait  = $urandom % 4;
                end else begin
                    beat_wait--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: no completion within %0d cycles", TIMEOUT);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    // returns 1 on a miss, fills the victim way
    function automatic logic cache_model_access(input paddr_t pa);
        logic [5:0]  set;
        logic [19:0] tag;
        int          way;
        logic        miss;
        set  = pa[11:6];
        tag  = pa[31:12];
        way  = -1;
        miss = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (m_val[set][w] && m_tag[w][set] == tag) begin
                way = w;
            end
        end
        if (way < 0) begin
            miss = 1'b1;
            way  = int'(m_lru[set]);
            m_val[set][way] = 1'b1;
            m_tag[way][set] = tag;
        end
        m_lru[set] = (way == 0);
        return miss;
    endfunction

    task automatic run_fetch(input vaddr_t va);
        fetch_out_t exp;
        paddr_t     pa;
        paddr_t     exp_addr;
        logic [7:0] exp_len;
        int         exp_req;
        int         exp_lookup;
        int         lookups0;
        int         hold;
        logic       exc;
        logic       unc;
        int         k;
        exp        = '0;
        exp_req    = 0;
        exp_lookup = 0;
        exp_addr   = '0;
        exp_len    = '0;
        exc        = 1'b0;
        if (va[31:30] == 2'b10) begin
            pa  = {3'b000, va[28:0]};
            unc = va[29];
        end else begin
            if (!(m_tlb_valid && m_vpn == va[31:13] && m_odd == va[12])) begin
                exp_lookup  = 1;
                k           = int'(va[31:13]) - 32'h200;
                m_vpn       = va[31:13];
                m_odd       = va[12];
                m_tlb_valid = 1'b0;
                if (!pt_found[k]) begin
                    exc = 1'b1;
                    exp.tlb_refill = 1'b1;
                end else if (!(m_odd ? pt_entry[k].v1 : pt_entry[k].v0)) begin
                    exc = 1'b1;
                    exp.tlb_invalid = 1'b1;
                end else begin
                    m_tlb_valid = 1'b1;
                    m_pfn = m_odd ? pt_entry[k].pfn1 : pt_entry[k].pfn0;
                    m_unc = (m_odd ? pt_entry[k].c1 : pt_entry[k].c0) == 3'd2;
                end
            end
            pa  = {m_pfn, va[11:0]};
            unc = m_unc;
        end
        exp.ok0 = 1'b1;
        if (exc) begin
            exp.rdata0 = '0;
        end else if (unc) begin
            exp_req    = 1;
            exp_addr   = pa;
            exp.rdata0 = mem_word(pa);
        end else begin
            exp_req    = cache_model_access(pa) ? 1 : 0;
            exp_addr   = {pa[31:6], 6'd0};
            exp_len    = 8'(`IFETCH_NR_WORDS - 1);
            exp.rdata0 = mem_word(pa);
            exp.rdata1 = mem_word({pa[31:3], 3'b100});
            exp.ok1    = ~va[2];
        end
        lookups0 = lookup_cnt;

        // one idle cycle so the arrays see inst_va_next
        inst_en      = 1'b0;
        inst_va      = va;
        inst_va_next = va;
        stall_f      = 1'b0;
        @(negedge clk);
        inst_en = 1'b1;
        do @(negedge clk); while (istall);

        check_word("fetch.rdata0", exp.rdata0, fetch.rdata0);
        check_word("fetch.rdata1", exp.rdata1, fetch.rdata1);
        check_fetch("fetch", exp, fetch);
        hold = $urandom % 3;
        repeat (hold) begin
            stall_f = 1'b1;
            @(negedge clk);
            check_fetch("fetch held", exp, fetch);
        end
        stall_f = 1'b0;
        @(negedge clk);

        if (lookup_cnt - lookups0 != exp_lookup) begin
            $display("L2 TLB lookup count wrong for va %08h", va);
            stop_run();
        end
        if (exp_lookup == 1) begin
            check_word("itlb_vpn2", {13'd0, va[31:13]}, {13'd0, itlb_vpn2});
        end
        if (req_addr_q.size() != exp_req) begin
            $display("wrong number of AXI read requests for va %08h", va);
            stop_run();
        end
        if (exp_req == 1) begin
            check_addr("araddr", exp_addr, req_addr_q.pop_front());
            check_word("arlen", {24'd0, exp_len}, {24'd0, req_len_q.pop_front()});
        end
    endtask

    task automatic run_fence(input logic is_i, input vaddr_t addr);
        inst_en    = 1'b0;
        fence_i    = is_i;
        fence_tlb  = ~is_i;
        fence_addr = addr;
        @(negedge clk);
        fence_i   = 1'b0;
        fence_tlb = 1'b0;
        @(negedge clk);
        if (istall) begin
            $display("fence did not return to idle after one cycle");
            stop_run();
        end
        if (is_i) begin
            m_val[addr[11:6]] = 2'b00;
        end
        m_tlb_valid = 1'b0;
    endtask

    initial begin
        vaddr_t     va;
        vaddr_t     prev_va;
        int         op;
        logic       last_fence;
        fetch_out_t quiet;
        void'($urandom(32'h38c1_846d));
        for (int s = 0; s < 64; s++) begin
            m_val[s] = 2'b00;
            m_lru[s] = 1'b0;
        end
        m_tlb_valid = 1'b0;
        // page table, entry 1 missing and odd half of entry 2 invalid
        for (int i = 0; i < 3; i++) begin
            pt_found[i] = 1'b1;
            pt_entry[i].pfn0 = pick_ptag($urandom);
            pt_entry[i].c0   = ($urandom % 4 == 0) ? 3'd2 : 3'd3;
            pt_entry[i].v0   = 1'b1;
            pt_entry[i].pfn1 = pick_ptag($urandom);
            pt_entry[i].c1   = ($urandom % 4 == 0) ? 3'd2 : 3'd3;
            pt_entry[i].v1   = 1'b1;
        end
        pt_found[1]    = 1'b0;
        pt_entry[2].v1 = 1'b0;

        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // outputs quiet after reset, fetch data is don't care
        quiet        = fetch;
        quiet.rdata0 = '0;
        quiet.rdata1 = '0;
        check_fetch("fetch after reset", '0, quiet);
        check_word("istall", 32'd0, {31'd0, istall});
        check_word("arvalid", 32'd0, {31'd0, arvalid});
        check_word("rready", 32'd0, {31'd0, rready});

        prev_va    = 32'h8001_1140;
        last_fence = 1'b0;
        for (int n = 0; n < NUM_OPS; n++) begin
            op = $urandom % 16;
            if (op >= 13 && op <= 14 && last_fence) begin
                op = 0;
            end
            if (op <= 6) begin
                va = 32'h8000_0000 | (32'(pick_ptag($urandom)) << 12);
            end else if (op <= 8) begin
                va = 32'ha000_0000 | (32'(pick_ptag($urandom)) << 12);
            end else begin
                va = {20'h00400 + 20'($urandom % 6), 12'd0};
            end
            va[11:6] = pick_set();
            va[5:2]  = 4'($urandom % 16);
            if (op == 15) begin
                va = prev_va;
            end
            if (op == 13 || op == 14) begin
                run_fence(op == 13, prev_va);
                last_fence = 1'b1;
            end else begin
                run_fetch(va);
                prev_va    = va;
                last_fence = 1'b0;
            end
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
